/* spi_test_slave.f */
+incdir+include
verilog/spi_test_slave_pkg.sv
verilog/spi_frontend.sv
verilog/pattern_checker.sv
verilog/reply_source.sv
verilog/test_regs.sv
verilog/spi_test_slave.sv
tb/spi_test_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the spi_test_slave testbench with Verilator
# everything goes to sim.log and the verdict is read back from it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module spi_test_slave_tb -f spi_test_slave.f > sim.log 2>&1 &&
	./obj_dir/Vspi_test_slave_tb >> sim.log 2>&1

grep -q "ALL TESTS PASSED" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

/* tb/spi_test_slave_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spi_test_slave_config.svh"

module spi_test_slave_tb;

	// sck half period in clk cycles
	localparam int SCK_HALF = 8;
	// bytes per frame in each test
	localparam int MATCH_BYTES = 20;
	localparam int MIX_BYTES = 12;
	localparam int REPLY_BYTES = 15;
	localparam int CLEAR_BYTES = 4;
	// two mixed frames, two frames around the clear
	localparam int SPI_BITS = 8 * (MATCH_BYTES + 2 * MIX_BYTES + REPLY_BYTES + 2 * CLEAR_BYTES);
	// 16 clk per bit plus room for register traffic and frame edges
	localparam int WATCHDOG_NS = (SPI_BITS * 16 + 3000) * 20;

	logic clk;
	logic rst_n;
	logic sck;
	logic ssel;
	logic mosi;
	logic miso;
	logic reg_wr;
	logic reg_rd;
	spi_test_slave_pkg::reg_addr_t reg_addr;
	spi_test_slave_pkg::byte_t reg_wdata;
	spi_test_slave_pkg::count_t reg_rdata;

	int error_count;
	int check_count;

	// ==============================
	// reference model state
	// ==============================
	spi_test_slave_pkg::byte_t model_base;
	spi_test_slave_pkg::byte_t model_reply_start;
	// next byte the slave should send
	spi_test_slave_pkg::byte_t model_reply;
	spi_test_slave_pkg::byte_t model_last;
	// pattern index since the last clear
	int model_index;
	int model_bytes;
	int model_matches;
	int model_mismatches;

	spi_test_slave u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.sck       (sck),
		.ssel      (ssel),
		.mosi      (mosi),
		.miso      (miso),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ends the run if the tests stall
	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// returns on a falling clk edge
	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_equal(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	// byte the counting pattern calls for at the current index
	function automatic spi_test_slave_pkg::byte_t pattern_byte();
		return spi_test_slave_pkg::byte_t'(model_base + model_index);
	endfunction

	// ==============================
	// host register access
	// ==============================
	task automatic reg_write(input spi_test_slave_pkg::reg_addr_t addr,
		input spi_test_slave_pkg::byte_t data);
		reg_addr = addr;
		reg_wdata = data;
		reg_wr = 1'b1;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	// rdata is registered on the clk after the strobe
	task automatic reg_read(input spi_test_slave_pkg::reg_addr_t addr,
		output spi_test_slave_pkg::count_t data);
		reg_addr = addr;
		reg_rd = 1'b1;
		@(negedge clk);
		reg_rd = 1'b0;
		data = reg_rdata;
	endtask

	task automatic read_and_check(input spi_test_slave_pkg::reg_addr_t addr, input string name,
		input logic [15:0] expected);
		spi_test_slave_pkg::count_t value;
		reg_read(addr, value);
		check_equal(name, value, expected);
	endtask

	task automatic set_check_base(input spi_test_slave_pkg::byte_t value);
		reg_write(`STS_REG_CHECK_BASE, value);
		model_base = value;
	endtask

	task automatic set_reply_start(input spi_test_slave_pkg::byte_t value);
		reg_write(`STS_REG_REPLY_START, value);
		model_reply_start = value;
	endtask

	// clear pulse, then one more clk for the checker and reply counter
	task automatic clear_link();
		reg_write(`STS_REG_CTRL, 8'h01);
		wait_clocks(2);
		model_index = 0;
		model_reply = model_reply_start;
		model_bytes = 0;
		model_matches = 0;
		model_mismatches = 0;
	endtask

	task automatic check_counts();
		read_and_check(`STS_REG_BYTE_COUNT, "BYTE_COUNT", model_bytes[15:0]);
		read_and_check(`STS_REG_MATCH_COUNT, "MATCH_COUNT", model_matches[15:0]);
		read_and_check(`STS_REG_MISMATCH_COUNT, "MISMATCH_COUNT", model_mismatches[15:0]);
		read_and_check(`STS_REG_LAST_RX, "LAST_RX", {8'h00, model_last});
	endtask

	// ==============================
	// spi master, mode 0
	// ==============================
	task automatic spi_start();
		ssel = 1'b0;
		wait_clocks(SCK_HALF);
	endtask

	// sck is already low here
	task automatic spi_stop();
		wait_clocks(SCK_HALF);
		ssel = 1'b1;
		wait_clocks(SCK_HALF);
	endtask

	// mosi changes with sck low, miso is taken at the rising edge
	task automatic spi_xfer_byte(input spi_test_slave_pkg::byte_t tx,
		output spi_test_slave_pkg::byte_t rx);
		int bit_idx;
		for (bit_idx = 7; bit_idx >= 0; bit_idx--) begin
			mosi = tx[bit_idx];
			wait_clocks(SCK_HALF);
			rx[bit_idx] = miso;
			sck = 1'b1;
			wait_clocks(SCK_HALF);
			sck = 1'b0;
		end
	endtask

	// one byte through the link, model updated by the counting rules
	task automatic exchange_byte(input spi_test_slave_pkg::byte_t tx,
		output spi_test_slave_pkg::byte_t rx);
		spi_test_slave_pkg::byte_t expected;
		expected = pattern_byte();
		spi_xfer_byte(tx, rx);
		check_equal("miso", {8'h00, rx}, {8'h00, model_reply});
		model_reply = model_reply - 8'd1;
		if (tx == expected) begin
			model_matches++;
		end else begin
			model_mismatches++;
		end
		model_index++;
		model_bytes++;
		model_last = tx;
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic test_reset_state();
		check_equal("miso", {15'd0, miso}, 16'h0001);
		read_and_check(`STS_REG_STATUS, "STATUS", 16'h0001);
		check_counts();
		read_and_check(`STS_REG_CHECK_BASE, "CHECK_BASE", 16'h0000);
		read_and_check(`STS_REG_REPLY_START, "REPLY_START", 16'h00FF);
	endtask

	task automatic test_register_access();
		spi_test_slave_pkg::byte_t base;
		spi_test_slave_pkg::byte_t start;
		base = spi_test_slave_pkg::byte_t'($urandom);
		start = spi_test_slave_pkg::byte_t'($urandom);
		set_check_base(base);
		set_reply_start(start);
		read_and_check(`STS_REG_CHECK_BASE, "CHECK_BASE", {8'h00, base});
		read_and_check(`STS_REG_REPLY_START, "REPLY_START", {8'h00, start});
		read_and_check(`STS_REG_CTRL, "CTRL", 16'h0000);
		// frame open with no sck activity
		spi_start();
		read_and_check(`STS_REG_STATUS, "STATUS", 16'h0003);
		spi_stop();
		read_and_check(`STS_REG_STATUS, "STATUS", 16'h0001);
	endtask

	task automatic test_matching_stream();
		spi_test_slave_pkg::byte_t base;
		spi_test_slave_pkg::byte_t rx;
		int n;
		base = spi_test_slave_pkg::byte_t'($urandom);
		set_check_base(base);
		clear_link();
		spi_start();
		for (n = 0; n < MATCH_BYTES; n++) begin
			exchange_byte(spi_test_slave_pkg::byte_t'(base + n), rx);
		end
		spi_stop();
		read_and_check(`STS_REG_BYTE_COUNT, "BYTE_COUNT", 16'd20);
		read_and_check(`STS_REG_MATCH_COUNT, "MATCH_COUNT", 16'd20);
		read_and_check(`STS_REG_MISMATCH_COUNT, "MISMATCH_COUNT", 16'd0);
		read_and_check(`STS_REG_LAST_RX, "LAST_RX", {8'h00, base + 8'd19});
	endtask

	task automatic test_mismatch_counting();
		spi_test_slave_pkg::byte_t tx;
		spi_test_slave_pkg::byte_t rx;
		int frame;
		int n;
		set_check_base(spi_test_slave_pkg::byte_t'($urandom));
		clear_link();
		for (frame = 0; frame < 2; frame++) begin
			spi_start();
			for (n = 0; n < MIX_BYTES; n++) begin
				// about half pattern bytes, half random ones
				if ($urandom % 2 == 0) begin
					tx = pattern_byte();
				end else begin
					tx = spi_test_slave_pkg::byte_t'($urandom);
				end
				exchange_byte(tx, rx);
			end
			spi_stop();
			check_counts();
		end
	endtask

	task automatic test_reply_sequence();
		spi_test_slave_pkg::byte_t start;
		spi_test_slave_pkg::byte_t rx;
		int frame;
		int frame_len;
		int n;
		int sent;
		start = spi_test_slave_pkg::byte_t'($urandom);
		set_reply_start(start);
		clear_link();
		sent = 0;
		for (frame = 0; frame < 3; frame++) begin
			// 5, 4 and 6 bytes
			frame_len = (frame == 0) ? 5 : (frame == 1) ? 4 : 6;
			spi_start();
			for (n = 0; n < frame_len; n++) begin
				exchange_byte(pattern_byte(), rx);
				check_equal("miso", {8'h00, rx}, {8'h00, start - sent[7:0]});
				sent++;
			end
			spi_stop();
		end
		check_counts();
	endtask

	task automatic test_clear();
		spi_test_slave_pkg::byte_t rx;
		int n;
		spi_start();
		for (n = 0; n < CLEAR_BYTES; n++) begin
			exchange_byte(spi_test_slave_pkg::byte_t'($urandom), rx);
		end
		spi_stop();
		clear_link();
		read_and_check(`STS_REG_BYTE_COUNT, "BYTE_COUNT", 16'd0);
		read_and_check(`STS_REG_MATCH_COUNT, "MATCH_COUNT", 16'd0);
		read_and_check(`STS_REG_MISMATCH_COUNT, "MISMATCH_COUNT", 16'd0);
		// pattern and reply restart at their base values
		spi_start();
		for (n = 0; n < CLEAR_BYTES; n++) begin
			exchange_byte(spi_test_slave_pkg::byte_t'(model_base + n), rx);
		end
		spi_stop();
		read_and_check(`STS_REG_MATCH_COUNT, "MATCH_COUNT", 16'd4);
		check_counts();
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		void'($urandom(55103));
		rst_n = 1'b0;
		sck = 1'b0;
		ssel = 1'b1;
		mosi = 1'b0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		error_count = 0;
		check_count = 0;
		// reset values of the register bank and reply counter
		model_base = 8'h00;
		model_reply_start = 8'hFF;
		model_reply = 8'hFF;
		model_last = 8'h00;
		model_index = 0;
		model_bytes = 0;
		model_matches = 0;
		model_mismatches = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		wait_clocks(2);
		test_reset_state();
		test_register_access();
		test_matching_stream();
		test_mismatch_counting();
		test_reply_sequence();
		test_clear();
		$display("checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/spi_test_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_test_slave (
	input  wire                               clk,
	input  wire                               rst_n,
	// spi pins
	input  wire                               sck,
	input  wire                               ssel,
	input  wire                               mosi,
	output logic                              miso,
	// host register strobes
	input  wire                               reg_wr,
	input  wire                               reg_rd,
	input  wire spi_test_slave_pkg::reg_addr_t reg_addr,
	input  wire spi_test_slave_pkg::byte_t     reg_wdata,
	output spi_test_slave_pkg::count_t         reg_rdata
);

	// ==============================
	// internal links
	// ==============================

	// completed bytes from the front end
	spi_test_slave_pkg::rx_event_t rx_event;
	// next reply byte for the shifter
	spi_test_slave_pkg::byte_t tx_byte;
	// base values and clear from the registers
	spi_test_slave_pkg::link_cfg_t link_cfg;
	// counts for readback
	spi_test_slave_pkg::check_result_t check_result;
	logic frame_active;

	// ==============================
	// blocks
	// ==============================

	spi_frontend u_frontend (
		.clk          (clk),
		.rst_n        (rst_n),
		.sck          (sck),
		.ssel         (ssel),
		.mosi         (mosi),
		.tx_byte      (tx_byte),
		.miso         (miso),
		.rx_event     (rx_event),
		.frame_active (frame_active)
	);

	pattern_checker u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_event     (rx_event),
		.link_cfg     (link_cfg),
		.check_result (check_result)
	);

	reply_source u_reply (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_event (rx_event),
		.link_cfg (link_cfg),
		.tx_byte  (tx_byte)
	);

	test_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.reg_wr       (reg_wr),
		.reg_rd       (reg_rd),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.check_result (check_result),
		.frame_active (frame_active),
		.reg_rdata    (reg_rdata),
		.link_cfg     (link_cfg)
	);

endmodule

`default_nettype wire

/* verilog/test_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "spi_test_slave_config.svh"

module test_regs (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire                                   reg_wr,
	input  wire                                   reg_rd,
	input  wire spi_test_slave_pkg::reg_addr_t     reg_addr,
	input  wire spi_test_slave_pkg::byte_t         reg_wdata,
	input  wire spi_test_slave_pkg::check_result_t check_result,
	input  wire                                   frame_active,
	output spi_test_slave_pkg::count_t             reg_rdata,
	output spi_test_slave_pkg::link_cfg_t          link_cfg
);

	// configuration registers
	spi_test_slave_pkg::byte_t check_base_q;
	spi_test_slave_pkg::byte_t reply_start_q;

	// self clearing clear pulse
	logic clear_q;
	// goes high once out of reset
	logic ready_q;

	// read mux output before the register
	spi_test_slave_pkg::count_t read_data;

	// ==============================
	// write side
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			check_base_q  <= 8'h00;
			reply_start_q <= 8'hFF;
			clear_q       <= 1'b0;
		end else begin
			// clear lasts a single clk
			clear_q <= 1'b0;
			if (reg_wr) begin
				case (reg_addr)
					`STS_REG_CTRL: begin
						clear_q <= reg_wdata[0];
					end
					`STS_REG_CHECK_BASE: begin
						check_base_q <= reg_wdata;
					end
					`STS_REG_REPLY_START: begin
						reply_start_q <= reg_wdata;
					end
					// status and count registers are read only
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b1;
		end
	end

	assign link_cfg.check_base  = check_base_q;
	assign link_cfg.reply_start = reply_start_q;
	assign link_cfg.clear       = clear_q;

	// ==============================
	// read side
	// ==============================

	// narrow registers are zero extended
	always_comb begin
		read_data = '0;
		case (reg_addr)
			`STS_REG_CTRL:           read_data = '0;
			`STS_REG_CHECK_BASE:     read_data = spi_test_slave_pkg::count_t'(check_base_q);
			`STS_REG_REPLY_START:    read_data = spi_test_slave_pkg::count_t'(reply_start_q);
			`STS_REG_BYTE_COUNT:     read_data = check_result.byte_count;
			`STS_REG_MATCH_COUNT:    read_data = check_result.match_count;
			`STS_REG_MISMATCH_COUNT: read_data = check_result.mismatch_count;
			`STS_REG_LAST_RX:        read_data = spi_test_slave_pkg::count_t'(check_result.last_rx);
			// bit 0 ready, bit 1 frame in progress
			`STS_REG_STATUS: read_data = spi_test_slave_pkg::count_t'({frame_active, ready_q});
			default:                 read_data = '0;
		endcase
	end

	// read data valid the clk after the strobe, held otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_rdata <= '0;
		end else if (reg_rd) begin
			reg_rdata <= read_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/reply_source.sv */
`timescale 1ns/10ps
`default_nettype none

module reply_source (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire spi_test_slave_pkg::rx_event_t rx_event,
	input  wire spi_test_slave_pkg::link_cfg_t link_cfg,
	output spi_test_slave_pkg::byte_t          tx_byte
);

	// ==============================
	// falling reply counter
	// ==============================

	// value the front end loads at the next byte boundary
	spi_test_slave_pkg::byte_t reply_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// matches the reply_start reset value
			reply_cnt <= 8'hFF;
		end else if (link_cfg.clear) begin
			reply_cnt <= link_cfg.reply_start;
		end else if (rx_event.valid) begin
			// one step down per byte, wraps modulo 256
			reply_cnt <= reply_cnt - 8'd1;
		end
	end

	// held as a level for the front end
	assign tx_byte = reply_cnt;

endmodule

`default_nettype wire

/* verilog/pattern_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module pattern_checker (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire spi_test_slave_pkg::rx_event_t rx_event,
	input  wire spi_test_slave_pkg::link_cfg_t link_cfg,
	output spi_test_slave_pkg::check_result_t  check_result
);

	// next byte the counting pattern should deliver
	spi_test_slave_pkg::byte_t expected;
	spi_test_slave_pkg::check_result_t result_q;

	// counters stop at all ones
	function automatic spi_test_slave_pkg::count_t sat_inc(
		input spi_test_slave_pkg::count_t value
	);
		if (&value) begin
			return value;
		end
		return value + 1'b1;
	endfunction

	// ==============================
	// pattern compare
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			expected <= 8'h00;
			result_q <= '0;
		end else if (link_cfg.clear) begin
			// restart the pattern at the programmed base
			expected <= link_cfg.check_base;
			result_q <= '0;
		end else if (rx_event.valid) begin
			// index carries on across frames
			expected            <= expected + 8'd1;
			result_q.byte_count <= sat_inc(result_q.byte_count);
			result_q.last_rx    <= rx_event.data;
			if (rx_event.data == expected) begin
				result_q.match_count <= sat_inc(result_q.match_count);
			end else begin
				result_q.mismatch_count <= sat_inc(result_q.mismatch_count);
			end
		end
	end

	assign check_result = result_q;

endmodule

`default_nettype wire

/* verilog/spi_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_frontend (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           sck,
	input  wire                           ssel,
	input  wire                           mosi,
	input  wire spi_test_slave_pkg::byte_t tx_byte,
	output logic                          miso,
	output spi_test_slave_pkg::rx_event_t rx_event,
	output logic                          frame_active
);

	// pin sampling shift registers
	logic [2:0] sck_sync;
	logic [2:0] ssel_sync;
	logic [1:0] mosi_sync;

	// decoded pin events
	logic sck_rise;
	logic sck_fall;
	logic ssel_start;
	logic ssel_active;
	logic mosi_bit;

	// byte assembly
	logic [2:0] bit_cnt;
	logic byte_done;
	spi_test_slave_pkg::byte_t rx_shift;
	spi_test_slave_pkg::byte_t tx_shift;

	// ==============================
	// pin synchronizers
	// ==============================

	// sck idles low in mode 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_sync <= 3'b000;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
		end
	end

	// ssel idles high so no frame shows after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ssel_sync <= 3'b111;
		end else begin
			ssel_sync <= {ssel_sync[1:0], ssel};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mosi_sync <= 2'b00;
		end else begin
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	// edge detect on the older two stages
	assign sck_rise    = (sck_sync[2:1] == 2'b01);
	assign sck_fall    = (sck_sync[2:1] == 2'b10);
	// ssel is active low
	assign ssel_active = ~ssel_sync[1];
	// frame opens on the ssel falling edge
	assign ssel_start  = (ssel_sync[2:1] == 2'b10);
	assign mosi_bit    = mosi_sync[1];

	assign frame_active = ssel_active;

	// ==============================
	// receive path
	// ==============================

	// bit counter, held at zero while deselected
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= 3'd0;
		end else if (!ssel_active) begin
			bit_cnt <= 3'd0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// msb first into the low end
	always_ff @(posedge clk) begin
		if (ssel_active && sck_rise) begin
			rx_shift <= {rx_shift[6:0], mosi_bit};
		end
	end

	// pulse once the eighth bit has been shifted in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_done <= 1'b0;
		end else begin
			byte_done <= ssel_active && sck_rise && (bit_cnt == 3'd7);
		end
	end

	// rx_shift is stable for several clk after the last bit
	assign rx_event.valid = byte_done;
	assign rx_event.data  = rx_shift;

	// ==============================
	// transmit path
	// ==============================

	// load at frame start and at each byte boundary
	// otherwise shift left on sck falling edges
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_shift <= 8'hFF;
		end else if (ssel_start) begin
			tx_shift <= tx_byte;
		end else if (ssel_active && sck_fall) begin
			if (bit_cnt == 3'd0) begin
				tx_shift <= tx_byte;
			end else begin
				tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

	// msb goes out first
	assign miso = tx_shift[7];

endmodule

`default_nettype wire

/* verilog/spi_test_slave_pkg.sv */
`default_nettype none

`include "spi_test_slave_config.svh"

package spi_test_slave_pkg;

	// one spi data byte
	typedef logic [7:0] byte_t;
	// byte, match and mismatch counters
	typedef logic [`STS_COUNT_W-1:0] count_t;
	// host register address
	typedef logic [`STS_ADDR_W-1:0] reg_addr_t;

	// completed byte from the front end, valid is a one clk pulse
	typedef struct packed {
		logic  valid;
		byte_t data;
	} rx_event_t;

	// checker counts and last byte seen
	typedef struct packed {
		count_t byte_count;
		count_t match_count;
		count_t mismatch_count;
		byte_t  last_rx;
	} check_result_t;

	// configuration from the register bank
	typedef struct packed {
		byte_t check_base;
		byte_t reply_start;
		logic  clear;
	} link_cfg_t;

endpackage

`default_nettype wire

/* include/spi_test_slave_config.svh */
`ifndef SPI_TEST_SLAVE_CONFIG_SVH
`define SPI_TEST_SLAVE_CONFIG_SVH

// width of the byte, match and mismatch counters
`define STS_COUNT_W 16

// host register address width
`define STS_ADDR_W 3

// ==============================
// register map
// ==============================
`define STS_REG_CTRL           3'd0
`define STS_REG_CHECK_BASE     3'd1
`define STS_REG_REPLY_START    3'd2
`define STS_REG_BYTE_COUNT     3'd3
`define STS_REG_MATCH_COUNT    3'd4
`define STS_REG_MISMATCH_COUNT 3'd5
`define STS_REG_LAST_RX        3'd6
`define STS_REG_STATUS         3'd7

`endif
